// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= audio_processor_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
src/audio_pkg.sv
src/audio_instr_decode.sv
src/bin_filter.sv
src/spectral_engine.sv
src/result_packer.sv
src/audio_processor.sv
tb/audio_processor_chk.sv
tb/audio_processor_tb.sv

// ==== src/audio_instr_decode.sv ====
module audio_instr_decode
    import audio_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_instr_valid,
    input  instr_t            i_instr,
    input  logic              i_busy,
    output logic              o_load_en,
    output load_req_t         o_load,
    output logic              o_coeff_en,
    output coeff_req_t        o_coeff,
    output logic              o_shift_en,
    output logic [BIN_W-1:0]  o_shift,
    output logic              o_start,
    output logic              o_sel_en,
    output logic [WSEL_W-1:0] o_sel
);

    logic idle_ok;

    // a start still in flight counts as busy because the engine has not seen it yet
    assign idle_ok = !i_busy && !o_start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_load_en  <= 1'b0;
            o_coeff_en <= 1'b0;
            o_shift_en <= 1'b0;
            o_start    <= 1'b0;
            o_sel_en   <= 1'b0;
        end else begin
            o_load_en  <= i_instr_valid && (i_instr.opcode == LDE) && idle_ok;
            o_start    <= i_instr_valid && (i_instr.opcode == SYN) && idle_ok;
            o_shift_en <= i_instr_valid && (i_instr.opcode == SPM) && idle_ok;
            o_coeff_en <= i_instr_valid && (i_instr.opcode == SFC) && idle_ok;
            o_sel_en   <= i_instr_valid && (i_instr.opcode == STE);  // never blocked
        end
    end

    // operands ride along, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (i_instr_valid) begin
            o_load.word  <= i_instr.index[WSEL_W-1:0];
            o_load.data  <= i_instr.payload;
            o_coeff.bin  <= i_instr.index;
            o_coeff.gain <= i_instr.payload[COEFF_W-1:0];
            o_shift      <= i_instr.payload[BIN_W-1:0];
            o_sel        <= i_instr.index[WSEL_W-1:0];
        end
    end

endmodule

// ==== src/audio_pkg.sv ====
package audio_pkg;

    // block geometry
    localparam int N_SAMPLES    = 16;
    localparam int SAMPLE_W     = 16;
    localparam int WORD_SAMPLES = 4;
    localparam int WORD_W       = WORD_SAMPLES * SAMPLE_W;  // 64
    localparam int N_WORDS      = N_SAMPLES / WORD_SAMPLES;  // 4
    localparam int BIN_W        = $clog2(N_SAMPLES);
    localparam int WSEL_W       = $clog2(N_WORDS);

    // arithmetic widths
    localparam int SPEC_W   = 20;  // 16 summed 16-bit samples
    localparam int ACC_W    = 24;  // inverse sums of SPEC_W bins
    localparam int COEFF_W  = 8;
    localparam int N_STAGES = 4;   // log2 of the block size

    // unsigned gain in 1/128 units
    localparam logic [COEFF_W-1:0] GAIN_UNITY = 8'd128;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef enum logic [2:0] {
        NOP,
        LDE,  // load sample word
        SYN,  // start processing
        SPM,  // set bin shift
        SFC,  // set bin gain
        STE   // select output word
    } opcode_t;

    typedef enum logic [2:0] {
        IDLE,
        FWD_XFORM,
        FILTER,
        INV_XFORM,
        EMIT
    } phase_t;

    typedef struct packed {
        opcode_t            opcode;
        logic [BIN_W-1:0]   index;    // word for LDE/STE, bin for SFC
        logic [WORD_W-1:0]  payload;
    } instr_t;

    typedef struct packed {
        logic [WSEL_W-1:0]  word;
        logic [WORD_W-1:0]  data;
    } load_req_t;

    typedef struct packed {
        logic [BIN_W-1:0]   bin;
        logic [COEFF_W-1:0] gain;
    } coeff_req_t;

    typedef struct packed {
        logic                     valid;
        logic [BIN_W-1:0]         bin;    // destination bin
        logic signed [SPEC_W-1:0] value;  // source bin contents
    } bin_req_t;

    typedef struct packed {
        logic                    valid;
        logic [BIN_W-1:0]        idx;
        logic signed [ACC_W-1:0] value;
    } emit_t;

endpackage

// ==== src/audio_processor.sv ====
module audio_processor
    import audio_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_instr_valid,
    input  instr_t            i_instr,
    output logic              o_busy,
    output logic              o_done,
    output logic [WORD_W-1:0] o_data
);

    logic                     load_en;
    load_req_t                load;
    logic                     coeff_en;
    coeff_req_t               coeff;
    logic                     shift_en;
    logic [BIN_W-1:0]         shift;
    logic                     start;
    logic                     sel_en;
    logic [WSEL_W-1:0]        sel;
    bin_req_t                 req;
    logic [BIN_W-1:0]         src;
    logic                     filt_valid;
    logic signed [SPEC_W-1:0] filt_bin;
    emit_t                    emit;

    audio_instr_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_instr_valid(i_instr_valid),
        .i_instr      (i_instr),
        .i_busy       (o_busy),
        .o_load_en    (load_en),
        .o_load       (load),
        .o_coeff_en   (coeff_en),
        .o_coeff      (coeff),
        .o_shift_en   (shift_en),
        .o_shift      (shift),
        .o_start      (start),
        .o_sel_en     (sel_en),
        .o_sel        (sel)
    );

    spectral_engine u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_load_en   (load_en),
        .i_load      (load),
        .i_start     (start),
        .i_src       (src),
        .i_filt_valid(filt_valid),
        .i_filt_bin  (filt_bin),
        .o_busy      (o_busy),
        .o_req       (req),
        .o_emit      (emit)
    );

    bin_filter u_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_coeff_en(coeff_en),
        .i_coeff   (coeff),
        .i_shift_en(shift_en),
        .i_shift   (shift),
        .i_req     (req),
        .o_src     (src),
        .o_valid   (filt_valid),
        .o_bin     (filt_bin)
    );

    result_packer u_packer (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_emit  (emit),
        .i_sel_en(sel_en),
        .i_sel   (sel),
        .o_done  (o_done),
        .o_data  (o_data)
    );

endmodule

// ==== src/bin_filter.sv ====
module bin_filter
    import audio_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_coeff_en,
    input  coeff_req_t               i_coeff,
    input  logic                     i_shift_en,
    input  logic [BIN_W-1:0]         i_shift,
    input  bin_req_t                 i_req,
    output logic [BIN_W-1:0]         o_src,
    output logic                     o_valid,
    output logic signed [SPEC_W-1:0] o_bin
);

    localparam int GAIN_SH = $clog2(GAIN_UNITY);  // 7
    localparam int PROD_W  = SPEC_W + COEFF_W + 1;

    logic [BIN_W-1:0]         shift_q;
    logic [COEFF_W-1:0]       gain_q [N_SAMPLES];
    logic                     in_range;
    logic signed [PROD_W-1:0] prod;

    // source of destination bin k is k - s, wrapped; out of range bins are zeroed below
    assign o_src    = i_req.bin - shift_q;
    assign in_range = (i_req.bin >= shift_q);

    // gain is unsigned, so extend it with a zero sign bit
    assign prod = i_req.value * $signed({1'b0, gain_q[i_req.bin]});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '0;
            o_valid <= 1'b0;
            for (int i = 0; i < N_SAMPLES; i++) begin
                gain_q[i] <= GAIN_UNITY;
            end
        end else begin
            if (i_shift_en) begin
                shift_q <= i_shift;
            end
            if (i_coeff_en) begin
                gain_q[i_coeff.bin] <= i_coeff.gain;
            end
            o_valid <= i_req.valid;
        end
    end

    // scale by 1/128 and truncate back to bin width
    always_ff @(posedge clk) begin
        if (in_range) begin
            o_bin <= prod[SPEC_W+GAIN_SH-1:GAIN_SH];
        end else begin
            o_bin <= '0;
        end
    end

endmodule

// ==== src/result_packer.sv ====
module result_packer
    import audio_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  emit_t             i_emit,
    input  logic              i_sel_en,
    input  logic [WSEL_W-1:0] i_sel,
    output logic              o_done,
    output logic [WORD_W-1:0] o_data
);

    // inverse Hadamard gains N, so drop log2(N) bits
    localparam int SCALE_SH = N_STAGES;

    localparam logic [BIN_W-1:0] LAST_IDX = BIN_W'(N_SAMPLES - 1);

    sample_t smp_q [N_SAMPLES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_done <= 1'b0;
            o_data <= '0;
            for (int i = 0; i < N_SAMPLES; i++) begin
                smp_q[i] <= '0;
            end
        end else begin
            // done follows the write of the last sample
            o_done <= i_emit.valid && (i_emit.idx == LAST_IDX);

            if (i_emit.valid) begin
                smp_q[i_emit.idx] <= i_emit.value[SAMPLE_W+SCALE_SH-1:SCALE_SH];
            end

            if (i_sel_en) begin
                for (int j = 0; j < WORD_SAMPLES; j++) begin
                    // sample 4w sits in the low bits
                    o_data[j*SAMPLE_W +: SAMPLE_W] <=
                        smp_q[BIN_W'(i_sel * WORD_SAMPLES + j)];
                end
            end
        end
    end

endmodule

// ==== src/spectral_engine.sv ====
module spectral_engine
    import audio_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_load_en,
    input  load_req_t                i_load,
    input  logic                     i_start,
    input  logic [BIN_W-1:0]         i_src,
    input  logic                     i_filt_valid,
    input  logic signed [SPEC_W-1:0] i_filt_bin,
    output logic                     o_busy,
    output bin_req_t                 o_req,
    output emit_t                    o_emit
);

    localparam int CNT_W   = 5;
    localparam int STAGE_W = $clog2(N_STAGES);
    localparam int PAIR_W  = BIN_W - 1;

    // last count of each phase
    localparam logic [CNT_W-1:0] XFORM_LAST  = CNT_W'(N_STAGES * N_SAMPLES / 2 - 1);
    localparam logic [CNT_W-1:0] FILTER_LAST = CNT_W'(N_SAMPLES);  // one extra for the pipe
    localparam logic [CNT_W-1:0] EMIT_LAST   = CNT_W'(N_SAMPLES - 1);

    phase_t                  phase;
    logic [CNT_W-1:0]        cnt;
    logic [STAGE_W-1:0]      stage;
    logic [PAIR_W-1:0]       pair;
    logic [PAIR_W-1:0]       low_mask;
    logic [BIN_W-1:0]        lo_idx;
    logic [BIN_W-1:0]        hi_idx;
    logic [BIN_W-1:0]        wr_bin;    // next filtered bin to store
    logic [BIN_W-1:0]        rd_addr;
    logic [BIN_W-1:0]        nbin;
    logic signed [ACC_W-1:0] bf_a;
    logic signed [ACC_W-1:0] bf_b;
    logic signed [ACC_W-1:0] bf_sum;
    logic signed [ACC_W-1:0] bf_dif;

    logic signed [ACC_W-1:0] mem_a [N_SAMPLES];  // samples, then forward spectrum
    logic signed [ACC_W-1:0] mem_b [N_SAMPLES];  // filtered spectrum, then output

    assign o_busy = (phase != IDLE);

    // 8 butterflies per stage, one per cycle
    assign stage = cnt[CNT_W-1:PAIR_W];
    assign pair  = cnt[PAIR_W-1:0];

    // insert a zero at bit 'stage' of the pair number to get the lower index
    always_comb begin
        low_mask = PAIR_W'((1 << stage) - 1);
        lo_idx   = {pair & ~low_mask, 1'b0} | {1'b0, pair & low_mask};
        hi_idx   = lo_idx | (BIN_W'(1) << stage);
    end

    always_comb begin
        bf_a   = (phase == INV_XFORM) ? mem_b[lo_idx] : mem_a[lo_idx];
        bf_b   = (phase == INV_XFORM) ? mem_b[hi_idx] : mem_a[hi_idx];
        bf_sum = bf_a + bf_b;
        bf_dif = bf_a - bf_b;
    end

    // o_src tracks the bin of the request on the wire, and the next bin's
    // source is simply one more, so the read runs a cycle ahead of the filter
    always_comb begin
        if (o_req.valid) begin
            rd_addr = i_src + BIN_W'(1);
            nbin    = o_req.bin + BIN_W'(1);
        end else begin
            rd_addr = i_src;
            nbin    = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= IDLE;
            cnt    <= '0;
            wr_bin <= '0;
            o_req  <= '0;
        end else begin
            if (phase == FILTER && cnt < FILTER_LAST) begin
                o_req.valid <= 1'b1;
                o_req.bin   <= nbin;
                o_req.value <= mem_a[rd_addr][SPEC_W-1:0];
            end else begin
                o_req <= '0;
            end

            if (i_filt_valid) begin
                wr_bin <= wr_bin + BIN_W'(1);  // wraps back to 0 after bin 15
            end

            cnt <= cnt + 1'b1;
            case (phase)
                IDLE: begin
                    cnt <= '0;
                    if (i_start) begin
                        phase <= FWD_XFORM;
                    end
                end
                FWD_XFORM: begin
                    if (cnt == XFORM_LAST) begin
                        phase <= FILTER;
                        cnt   <= '0;
                    end
                end
                FILTER: begin
                    if (cnt == FILTER_LAST) begin
                        phase <= INV_XFORM;
                        cnt   <= '0;
                    end
                end
                INV_XFORM: begin
                    if (cnt == XFORM_LAST) begin
                        phase <= EMIT;
                        cnt   <= '0;
                    end
                end
                EMIT: begin
                    if (cnt == EMIT_LAST) begin
                        phase <= IDLE;
                        cnt   <= '0;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_SAMPLES; i++) begin
                mem_a[i] <= '0;
            end
        end else if (i_load_en) begin
            for (int j = 0; j < WORD_SAMPLES; j++) begin
                mem_a[BIN_W'(i_load.word * WORD_SAMPLES + j)] <=
                    ACC_W'(sample_t'(i_load.data[j*SAMPLE_W +: SAMPLE_W]));
            end
        end else if (phase == FWD_XFORM) begin
            mem_a[lo_idx] <= bf_sum;
            mem_a[hi_idx] <= bf_dif;
        end
    end

    // bin 15 lands during the first inverse cycle, which only touches bins 0 and 1
    always_ff @(posedge clk) begin
        if (i_filt_valid) begin
            mem_b[wr_bin] <= ACC_W'(i_filt_bin);
        end
        if (phase == INV_XFORM) begin
            mem_b[lo_idx] <= bf_sum;
            mem_b[hi_idx] <= bf_dif;
        end
    end

    always_comb begin
        o_emit.valid = (phase == EMIT);
        o_emit.idx   = cnt[BIN_W-1:0];
        o_emit.value = mem_b[cnt[BIN_W-1:0]];
    end

endmodule

// ==== tb/audio_processor_chk.sv ====
module audio_processor_chk
    import audio_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   i_busy,
    input logic   i_done,
    input logic   i_start,
    input phase_t i_phase
);

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        i_done |=> !i_done)
        else $error("o_done stayed high for more than one cycle");

    // the pulse comes in the first idle cycle
    done_idle: assert property (@(posedge clk) disable iff (!rst_n)
        i_done |-> !i_busy && $past(i_busy))
        else $error("o_done high while busy or without a preceding run");

    done_at_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(i_busy) |-> i_done)
        else $error("o_busy fell without an o_done pulse");

    // decode holds back a start that would reach a running engine
    start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        i_start |-> (i_phase == IDLE))
        else $error("start strobe reached the engine outside IDLE");

endmodule

// ==== tb/audio_processor_tb.sv ====
module audio_processor_tb
    import audio_pkg::*;
();

    localparam int          N_TESTS      = 10;
    localparam int          DONE_TIMEOUT = 500;
    localparam int          BUSY_TIMEOUT = 20;
    localparam logic [31:0] LCG_SEED     = 32'd52456;

    typedef enum logic [1:0] {PAT_IMPULSE, PAT_CONST, PAT_RANDOM} pattern_t;
    typedef enum logic [1:0] {GM_DEFAULT, GM_UNITY, GM_ZERO, GM_RAMP} gain_mode_t;

    typedef struct packed {
        logic [8*16-1:0]  name;
        pattern_t         pattern;
        logic [BIN_W-1:0] shift;
        gain_mode_t       gain_mode;  // GM_DEFAULT sends no SPM or SFC
        logic             busy_cmds;  // LDE, SFC, SPM, SYN while busy
    } test_row_t;

    logic              clk;
    logic              rst_n;
    logic              i_instr_valid;
    instr_t            i_instr;
    logic              o_busy;
    logic              o_done;
    logic [WORD_W-1:0] o_data;

    test_row_t          tests [N_TESTS];
    sample_t            samples [N_SAMPLES];
    logic [COEFF_W-1:0] gains [N_SAMPLES];
    logic [BIN_W-1:0]   shift_val;
    logic [WORD_W-1:0]  expected [N_WORDS];
    logic [31:0]        lcg_state;

    audio_processor dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_instr_valid(i_instr_valid),
        .i_instr      (i_instr),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_data       (o_data)
    );

    bind audio_processor audio_processor_chk u_chk (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_busy (o_busy),
        .i_done (o_done),
        .i_start(start),
        .i_phase(u_engine.phase)
    );

    always #5 clk = ~clk;

    task automatic build_table();
        tests[0] = '{"defaults", PAT_IMPULSE, 4'd0, GM_DEFAULT, 1'b0};  // reset state
        tests[1] = '{"unity_const", PAT_CONST, 4'd0, GM_UNITY, 1'b0};
        tests[2] = '{"unity_random", PAT_RANDOM, 4'd0, GM_UNITY, 1'b0};
        tests[3] = '{"zero_gain", PAT_RANDOM, 4'd0, GM_ZERO, 1'b0};
        tests[4] = '{"shift3_impulse", PAT_IMPULSE, 4'd3, GM_UNITY, 1'b0};
        tests[5] = '{"shift9_ramp_imp", PAT_IMPULSE, 4'd9, GM_RAMP, 1'b0};
        tests[6] = '{"ramp_random", PAT_RANDOM, 4'd0, GM_RAMP, 1'b0};
        tests[7] = '{"ramp_random_s2", PAT_RANDOM, 4'd2, GM_RAMP, 1'b0};
        tests[8] = '{"busy_cmds", PAT_RANDOM, 4'd5, GM_RAMP, 1'b1};
        tests[9] = '{"unity_after", PAT_RANDOM, 4'd0, GM_UNITY, 1'b0};
    endtask

    task automatic report_failure(input string msg);
        $display("%0s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // called at 1 unit past a rising edge, returns at the same point of the next cycle
    task automatic send_instr(input opcode_t op, input logic [BIN_W-1:0] idx,
                              input logic [WORD_W-1:0] data);
        i_instr_valid  = 1'b1;
        i_instr.opcode  = op;
        i_instr.index   = idx;
        i_instr.payload = data;
        @(posedge clk);
        #1;
        i_instr_valid = 1'b0;
    endtask

    task automatic fill_block(input pattern_t pat);
        for (int i = 0; i < N_SAMPLES; i++) begin
            case (pat)
                PAT_IMPULSE: samples[i] = (i == 0) ? 16'sd3000 : 16'sd0;
                PAT_CONST:   samples[i] = -16'sd1234;
                default:     samples[i] = sample_t'(lcg_next() >> 16);  // upper bits
            endcase
        end
    endtask

    task automatic set_gains(input gain_mode_t mode);
        for (int k = 0; k < N_SAMPLES; k++) begin
            case (mode)
                GM_ZERO: gains[k] = '0;
                GM_RAMP: gains[k] = COEFF_W'(8 * (k + 1));  // 8 up to 128
                default: gains[k] = GAIN_UNITY;
            endcase
        end
    endtask

    // direct Hadamard sums, shift, gain, inverse, scale
    task automatic compute_expected();
        longint              spec [N_SAMPLES];
        longint              filt [N_SAMPLES];
        longint              acc;
        logic [SAMPLE_W-1:0] out_s;
        for (int k = 0; k < N_SAMPLES; k++) begin
            acc = 0;
            for (int n = 0; n < N_SAMPLES; n++) begin
                if ($countones(k & n) % 2 == 1) acc -= samples[n];
                else acc += samples[n];
            end
            spec[k] = acc;
        end
        for (int k = 0; k < N_SAMPLES; k++) begin
            if (k >= shift_val) filt[k] = (spec[k - shift_val] * longint'(gains[k])) >>> 7;
            else filt[k] = 0;  // no source bin below the shift
        end
        for (int n = 0; n < N_SAMPLES; n++) begin
            acc = 0;
            for (int k = 0; k < N_SAMPLES; k++) begin
                if ($countones(k & n) % 2 == 1) acc -= filt[k];
                else acc += filt[k];
            end
            out_s = SAMPLE_W'(acc >>> 4);
            expected[n / WORD_SAMPLES][(n % WORD_SAMPLES)*SAMPLE_W +: SAMPLE_W] = out_s;
        end
    endtask

    task automatic wait_busy(input string tname);
        int cycles;
        cycles = 0;
        while (!o_busy && cycles < BUSY_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (o_busy) else report_failure($sformatf("%0s: o_busy never rose", tname));
    endtask

    task automatic wait_done(input string tname);
        int cycles;
        cycles = 0;
        while (!o_done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (o_done)
            else report_failure($sformatf("%0s: timed out waiting for o_done", tname));
    endtask

    task automatic read_and_check(input string tname);
        for (int w = 0; w < N_WORDS; w++) begin
            send_instr(STE, BIN_W'(w), '0);
            @(posedge clk);  // o_data follows the select strobe by one cycle
            #1;
            assert (o_data === expected[w])
                else report_failure($sformatf("MISMATCH %0s word %0d expected %h actual %h",
                                              tname, w, expected[w], o_data));
        end
    endtask

    task automatic run_test(input test_row_t row);
        string             tname;
        logic [WORD_W-1:0] word;
        tname = string'(row.name);
        fill_block(row.pattern);
        for (int w = 0; w < N_WORDS; w++) begin
            for (int j = 0; j < WORD_SAMPLES; j++) begin
                word[j*SAMPLE_W +: SAMPLE_W] = samples[w*WORD_SAMPLES + j];
            end
            send_instr(LDE, BIN_W'(w), word);
        end
        if (row.gain_mode == GM_DEFAULT) begin
            shift_val = '0;
            set_gains(GM_UNITY);
        end else begin
            shift_val = row.shift;
            set_gains(row.gain_mode);
            send_instr(SPM, '0, WORD_W'(row.shift));
            for (int k = 0; k < N_SAMPLES; k++) begin
                send_instr(SFC, BIN_W'(k), WORD_W'(gains[k]));
            end
        end
        compute_expected();
        send_instr(SYN, '0, '0);
        if (row.busy_cmds) begin
            wait_busy(tname);
            send_instr(LDE, 4'd1, {4{16'h7fff}});
            send_instr(SFC, 4'd9, '0);
            send_instr(SPM, '0, WORD_W'(4'hf));
            send_instr(SYN, '0, '0);
        end
        wait_done(tname);
        read_and_check(tname);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        lcg_state     = LCG_SEED;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        assert (!o_busy && !o_done) else report_failure("o_busy or o_done high after reset");
        for (int w = 0; w < N_WORDS; w++) begin
            expected[w] = '0;
        end
        read_and_check("after_reset");

        for (int t = 0; t < N_TESTS; t++) begin
            run_test(tests[t]);
        end

        $display("** PASS **");
        $finish;
    end

endmodule
